// ==== compile.f ====
calc_pkg.sv
operand_memory.sv
calc_alu.sv
calc_control.sv
calc_top.sv
calc_tb.sv

// ==== Bender.yml ====
package:
  name: calc

sources:
  - calc_pkg.sv
  - operand_memory.sv
  - calc_alu.sv
  - calc_control.sv
  - calc_top.sv
  - target: test
    files:
      - calc_tb.sv

// ==== calc_tb.sv ====
`default_nettype none

module calc_tb;
    import calc_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_ROWS     = 11;
    localparam int FIXED_ROWS   = 7;
    localparam int ROW_CYCLES   = 60;   // Upper bound on one row, keys plus multiply
    localparam int WAIT_LIMIT   = 40;   // Cycles allowed from equal key to complete
    localparam int WATCHDOG_TIME = (NUM_ROWS * ROW_CYCLES + RESET_CYCLES + 10) * CLK_PERIOD;

    // One row of the stimulus table
    typedef struct packed {
        logic [31:0] first;      // Decimal value as typed, may exceed 16 bits
        calc_op_t    op;
        logic [31:0] second;
        logic        busy_keys;  // Early equal and extra keys while busy
        word_t       expected;
    } calc_row_t;

    logic     clk;
    logic     reset;
    logic     key_valid;
    digit_t   key_digit;
    logic     op_valid;
    calc_op_t op_code;
    logic     equal_key;
    logic     busy;
    logic     complete;
    word_t    display;

    calc_row_t   table_rows [NUM_ROWS];
    int          error_count = 0;
    int          rows_failed = 0;
    int unsigned lcg_state   = 47;

    calc_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .key_valid (key_valid),
        .key_digit (key_digit),
        .op_valid  (op_valid),
        .op_code   (op_code),
        .equal_key (equal_key),
        .busy      (busy),
        .complete  (complete),
        .display   (display)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Value left after typing the decimal digits, times ten plus digit each
    function automatic word_t wrap_entry(logic [31:0] value);
        int          digits[$];
        logic [31:0] v;
        logic [31:0] acc;
        v   = value;
        acc = 0;
        if (v == 0) begin
            digits.push_front(0);
        end
        while (v > 0) begin
            digits.push_front(int'(v % 10));
            v = v / 10;
        end
        foreach (digits[k]) begin
            acc = ((acc * 10) + digits[k]) & 32'h0000_FFFF;
        end
        return word_t'(acc);
    endfunction

    function automatic word_t expected_result(word_t a, calc_op_t op, word_t b);
        logic [31:0] full;
        case (op)
            OP_SUB:  full = 32'd65536 + a - b;
            OP_MUL:  full = 32'(a) * 32'(b);
            default: full = 32'(a) + 32'(b);
        endcase
        return word_t'(full & 32'h0000_FFFF);
    endfunction

    function automatic string op_symbol(calc_op_t op);
        case (op)
            OP_SUB:  return "-";
            OP_MUL:  return "*";
            default: return "+";
        endcase
    endfunction

    task automatic set_row(int idx, logic [31:0] first, calc_op_t op, logic [31:0] second,
                           logic busy_keys);
        table_rows[idx].first     = first;
        table_rows[idx].op        = op;
        table_rows[idx].second    = second;
        table_rows[idx].busy_keys = busy_keys;
        table_rows[idx].expected  = expected_result(wrap_entry(first), op, wrap_entry(second));
    endtask

    task automatic check_word(string what, word_t got, word_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    // All key tasks start and end one time unit after a rising edge
    task automatic press_number(logic [31:0] value);
        int          digits[$];
        logic [31:0] v;
        v = value;
        if (v == 0) begin
            digits.push_front(0);
        end
        while (v > 0) begin
            digits.push_front(int'(v % 10));
            v = v / 10;
        end
        foreach (digits[k]) begin
            key_valid = 1'b1;
            key_digit = digit_t'(digits[k]);
            @(posedge clk);
            #1;
            key_valid = 1'b0;
        end
    endtask

    task automatic press_op(calc_op_t op);
        op_valid = 1'b1;
        op_code  = op;
        @(posedge clk);
        #1;
        op_valid = 1'b0;
    endtask

    task automatic press_equal();
        equal_key = 1'b1;
        @(posedge clk);
        #1;
        equal_key = 1'b0;
    endtask

    // Busy must stay high on every cycle before the complete pulse
    task automatic wait_complete(int row, output logic seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !seen; n++) begin
            @(posedge clk);
            #1;
            if (complete === 1'b1) begin
                seen = 1'b1;
            end else begin
                check_bit("busy while computing", busy, 1'b1);
            end
        end
        if (!seen) begin
            $display("Timeout in row %0d: no complete pulse within %0d cycles", row, WAIT_LIMIT);
            error_count++;
        end
    endtask

    task automatic run_row(int idx);
        calc_row_t row;
        logic      seen;
        int        errors_before;
        row           = table_rows[idx];
        errors_before = error_count;
        if (row.busy_keys) begin
            press_number(row.first);
            press_equal();           // No operator yet, must be ignored
            check_bit("busy after early equal", busy, 1'b0);
            press_op(row.op);
        end else begin
            press_number(row.first);
            press_op(row.op);
        end
        press_number(row.second);
        check_bit("busy during entry", busy, 1'b0);
        check_bit("complete during entry", complete, 1'b0);
        press_equal();
        check_bit("busy after equal", busy, 1'b1);
        if (row.busy_keys) begin
            press_number(32'd7);     // All three dropped by the controller
            press_op(OP_MUL);
            press_equal();
        end
        wait_complete(idx, seen);
        if (seen) begin
            check_word("display", display, row.expected);
            check_bit("busy at complete", busy, 1'b1);
            @(posedge clk);
            #1;
            check_bit("complete one cycle later", complete, 1'b0);
            check_bit("busy after complete", busy, 1'b0);
            check_word("display held", display, row.expected);
        end
        if (error_count != errors_before) begin
            rows_failed++;
        end
        $display("Row %0d: %0d %s %0d = %0d, %s", idx, row.first, op_symbol(row.op),
                 row.second, row.expected,
                 (error_count == errors_before) ? "pass" : "mismatch");
    endtask

    // Watchdog
    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired after %0d time units, run stopped", WATCHDOG_TIME);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int i;
        clk       = 1'b0;
        reset     = 1'b1;
        key_valid = 1'b0;
        key_digit = '0;
        op_valid  = 1'b0;
        op_code   = OP_ADD;
        equal_key = 1'b0;

        set_row(0, 32'd1050, OP_ADD, 32'd307, 1'b0);       // Zero digits inside operands
        set_row(1, 32'd25, OP_SUB, 32'd400, 1'b0);         // Negative difference wraps
        set_row(2, 32'd300, OP_MUL, 32'd250, 1'b0);
        set_row(3, 32'd65535, OP_MUL, 32'd65535, 1'b0);    // Low half of a full product
        set_row(4, 32'd123456, OP_ADD, 32'd7, 1'b0);       // First operand overflows entry
        set_row(5, 32'd42, OP_ADD, 32'd8, 1'b1);
        set_row(6, 32'd7, OP_MUL, 32'd6, 1'b0);            // Must not see keys from row 5
        for (i = FIXED_ROWS; i < NUM_ROWS; i++) begin
            set_row(i, (lcg_next() >> 8) % 200000, calc_op_t'((lcg_next() >> 8) % 3),
                    (lcg_next() >> 8) % 70000, 1'b0);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        check_bit("busy after reset", busy, 1'b0);
        check_bit("complete after reset", complete, 1'b0);
        check_word("display after reset", display, word_t'(0));

        for (i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        $display("Rows run %0d, rows passed %0d, rows failed %0d, failed checks %0d",
                 NUM_ROWS, NUM_ROWS - rows_failed, rows_failed, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== calc_top.sv ====
`default_nettype none

module calc_top (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     key_valid,
    input  wire calc_pkg::digit_t   key_digit,
    input  wire                     op_valid,
    input  wire calc_pkg::calc_op_t op_code,
    input  wire                     equal_key,
    output logic                    busy,
    output logic                    complete,
    output calc_pkg::word_t         display
);
    import calc_pkg::*;

    logic      mem_we;
    mem_wr_t   mem_wr;
    mem_addr_t mem_rd_addr;
    word_t     rd_data;

    logic      alu_start;
    alu_req_t  alu_req;
    logic      alu_finish;
    word_t     alu_result;

    calc_control u_control (
        .clk         (clk),
        .reset       (reset),
        .key_valid   (key_valid),
        .key_digit   (key_digit),
        .op_valid    (op_valid),
        .op_code     (op_code),
        .equal_key   (equal_key),
        .mem_we      (mem_we),
        .mem_wr      (mem_wr),
        .mem_rd_addr (mem_rd_addr),
        .rd_data     (rd_data),
        .alu_start   (alu_start),
        .alu_req     (alu_req),
        .alu_finish  (alu_finish),
        .alu_result  (alu_result),
        .busy        (busy),
        .complete    (complete),
        .display     (display)
    );

    // Operands and last result
    operand_memory u_memory (
        .clk     (clk),
        .mem_we  (mem_we),
        .mem_wr  (mem_wr),
        .rd_addr (mem_rd_addr),
        .rd_data (rd_data)
    );

    calc_alu u_alu (
        .clk        (clk),
        .reset      (reset),
        .alu_start  (alu_start),
        .alu_req    (alu_req),
        .alu_finish (alu_finish),
        .alu_result (alu_result)
    );

endmodule

`default_nettype wire

// ==== calc_control.sv ====
`default_nettype none

module calc_control (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      key_valid,
    input  wire calc_pkg::digit_t    key_digit,
    input  wire                      op_valid,
    input  wire calc_pkg::calc_op_t  op_code,
    input  wire                      equal_key,
    output logic                     mem_we,
    output calc_pkg::mem_wr_t        mem_wr,
    output calc_pkg::mem_addr_t      mem_rd_addr,
    input  wire calc_pkg::word_t     rd_data,
    output logic                     alu_start,
    output calc_pkg::alu_req_t       alu_req,
    input  wire                      alu_finish,
    input  wire calc_pkg::word_t     alu_result,
    output logic                     busy,
    output logic                     complete,
    output calc_pkg::word_t          display
);
    import calc_pkg::*;

    typedef enum logic [2:0] {
        S_FIRST_NUM   = 3'd0,
        S_SECOND_NUM  = 3'd1,
        S_READ_FIRST  = 3'd2,
        S_READ_SECOND = 3'd3,
        S_START_ALU   = 3'd4,
        S_WAIT_ALU    = 3'd5,
        S_SHOW_RESULT = 3'd6
    } calc_state_t;

    calc_state_t state;
    calc_state_t state_next;

    word_t    operand_first;   // First number as typed
    word_t    operand_second;  // Second number as typed
    calc_op_t op_reg;          // Operator, stored when the first number ends
    word_t    first_rd;        // First operand read back from memory

    logic     in_entry;
    logic     digit_ok;
    logic     op_accept;
    logic     equal_accept;
    logic     entry_write;
    logic     result_take;
    word_t    entry_value;
    word_t    entry_next;
    mem_wr_t  entry_wr;

    assign in_entry     = (state == S_FIRST_NUM) || (state == S_SECOND_NUM);
    assign digit_ok     = in_entry && key_valid && (key_digit <= digit_t'(9));
    assign op_accept    = (state == S_FIRST_NUM) && op_valid;
    assign equal_accept = (state == S_SECOND_NUM) && equal_key;
    assign result_take  = (state == S_WAIT_ALU) && alu_finish;

    // Every accepted key rewrites the operand under entry, so the
    // memory copy is current even when no digit was typed
    assign entry_write = digit_ok || op_accept || equal_accept;

    // Times ten plus digit, wraps at 16 bits
    assign entry_value = (state == S_SECOND_NUM) ? operand_second : operand_first;
    assign entry_next  = (entry_value << 3) + (entry_value << 1) + word_t'(key_digit);

    always_comb begin
        entry_wr.addr = (state == S_SECOND_NUM) ? ADDR_SECOND : ADDR_FIRST;
        entry_wr.data = digit_ok ? entry_next : entry_value;
    end

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            S_FIRST_NUM: begin
                if (op_accept) begin
                    state_next = S_SECOND_NUM;
                end
            end
            S_SECOND_NUM: begin
                if (equal_accept) begin
                    state_next = S_READ_FIRST;
                end
            end
            S_READ_FIRST:  state_next = S_READ_SECOND;
            S_READ_SECOND: state_next = S_START_ALU;
            S_START_ALU:   state_next = S_WAIT_ALU;
            S_WAIT_ALU: begin
                if (alu_finish) begin
                    state_next = S_SHOW_RESULT;
                end
            end
            S_SHOW_RESULT: state_next = S_FIRST_NUM;
            default:       state_next = S_FIRST_NUM;
        endcase
    end

    // State, operands and strobes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= S_FIRST_NUM;
            operand_first  <= '0;
            operand_second <= '0;
            mem_we         <= 1'b0;
            complete       <= 1'b0;
            display        <= '0;
        end else begin
            state    <= state_next;
            mem_we   <= entry_write || result_take;
            complete <= result_take;
            if (digit_ok) begin
                if (state == S_SECOND_NUM) begin
                    operand_second <= entry_next;
                end else begin
                    operand_first <= entry_next;
                end
            end
            if (result_take) begin
                display <= alu_result;
            end
            if (state == S_SHOW_RESULT) begin
                operand_first  <= '0;  // Next calculation starts clean
                operand_second <= '0;
            end
        end
    end

    // Write request, operator and read-back capture
    always_ff @(posedge clk) begin
        if (entry_write) begin
            mem_wr <= entry_wr;
        end else if (result_take) begin
            mem_wr <= '{addr: ADDR_RESULT, data: alu_result};
        end
        if (op_accept) begin
            op_reg <= op_code;
        end
        if (state == S_READ_SECOND) begin
            first_rd <= rd_data;  // Data for the S_READ_FIRST address
        end
    end

    // Read address follows the read-back states
    assign mem_rd_addr = (state == S_READ_SECOND) ? ADDR_SECOND : ADDR_FIRST;

    // Second operand comes straight off the memory read port
    assign alu_start = (state == S_START_ALU);

    always_comb begin
        alu_req.op        = op_reg;
        alu_req.operand_a = first_rd;
        alu_req.operand_b = rd_data;
    end

    assign busy = !in_entry;  // Keys are dropped outside entry

endmodule

`default_nettype wire

// ==== calc_alu.sv ====
`default_nettype none

module calc_alu (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     alu_start,
    input  wire calc_pkg::alu_req_t alu_req,
    output logic                    alu_finish,
    output calc_pkg::word_t         alu_result
);
    import calc_pkg::*;

    logic                         mul_busy;    // Shift-add loop running
    logic [$clog2(MUL_STEPS)-1:0] step_cnt;    // Current multiplier bit
    logic                         last_step;
    logic                         take_start;  // Start accepted this cycle
    word_t                        mcand;       // Multiplicand, shifted left
    word_t                        mplier;      // Multiplier, shifted right
    word_t                        acc;         // Running product, low bits only
    word_t                        partial;

    assign take_start = alu_start && !mul_busy;
    assign last_step  = (int'(step_cnt) == MUL_STEPS - 1);

    // Add the shifted multiplicand when the current bit is set
    assign partial = mplier[0] ? mcand : '0;

    // Sequencing and finish pulse
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mul_busy   <= 1'b0;
            step_cnt   <= '0;
            alu_finish <= 1'b0;
        end else begin
            alu_finish <= 1'b0;
            if (mul_busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (last_step) begin
                    mul_busy   <= 1'b0;
                    alu_finish <= 1'b1;
                end
            end else if (take_start) begin
                if (alu_req.op == OP_MUL) begin
                    mul_busy <= 1'b1;
                    step_cnt <= '0;
                end else begin
                    alu_finish <= 1'b1;  // Add and subtract in one cycle
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (mul_busy) begin
            acc    <= acc + partial;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            if (last_step) begin
                alu_result <= acc + partial;
            end
        end else if (take_start) begin
            case (alu_req.op)
                OP_MUL: begin
                    acc    <= '0;
                    mcand  <= alu_req.operand_a;
                    mplier <= alu_req.operand_b;
                end
                OP_SUB: begin
                    alu_result <= alu_req.operand_a - alu_req.operand_b;  // Wraps
                end
                default: begin
                    alu_result <= alu_req.operand_a + alu_req.operand_b;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== operand_memory.sv ====
`default_nettype none

module operand_memory (
    input  wire                      clk,
    input  wire                      mem_we,
    input  wire calc_pkg::mem_wr_t   mem_wr,
    input  wire calc_pkg::mem_addr_t rd_addr,
    output calc_pkg::word_t          rd_data
);
    import calc_pkg::*;

    // Holds both operands and the last result
    word_t mem [MEM_DEPTH];

    // Synchronous write port
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_wr.addr] <= mem_wr.data;
        end
    end

    // Registered read, same-address read returns the old word
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== calc_pkg.sv ====
`default_nettype none

package calc_pkg;

    localparam int WORD_W    = 16;   // Operand and result width
    localparam int MEM_DEPTH = 16;   // Operand memory words
    localparam int MUL_STEPS = 16;   // One multiplier bit per step

    // Operand, result and memory word
    typedef logic [WORD_W-1:0] word_t;

    // Decimal key value, 0 to 9 are valid
    typedef logic [3:0] digit_t;

    typedef logic [$clog2(MEM_DEPTH)-1:0] mem_addr_t;

    // Memory map of the operand memory
    localparam mem_addr_t ADDR_FIRST  = mem_addr_t'(0);  // First operand
    localparam mem_addr_t ADDR_SECOND = mem_addr_t'(1);  // Second operand
    localparam mem_addr_t ADDR_RESULT = mem_addr_t'(2);  // Last result

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } calc_op_t;

    // One write request into the operand memory
    typedef struct packed {
        mem_addr_t addr;
        word_t     data;
    } mem_wr_t;

    // Arithmetic request, latched by the unit on start
    typedef struct packed {
        calc_op_t op;
        word_t    operand_a;   // Left operand
        word_t    operand_b;   // Right operand, multiplier for OP_MUL
    } alu_req_t;

endpackage

`default_nettype wire
